/* src/fetch_pkg.sv */
package fetch_pkg;

    // byte address of an instruction or a fetched word.
    typedef logic [31:0] addr_t;

    // one instruction-memory word, or one full-length instruction.
    typedef logic [31:0] word_t;

    // log2 of the number of prefetch buffer entries.
    localparam int unsigned PREFETCH_DEPTH = 3;

    // index of one entry in the prefetch buffer.
    typedef logic [PREFETCH_DEPTH-1:0] buf_idx_t;

    // addi x0, x0, 0.
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

/* src/prefetch_buffer.sv */
`timescale 1ns/1ps

module prefetch_buffer (
    input  logic               clk,
    input  logic               rst,
    input  fetch_pkg::addr_t   pc,
    input  fetch_pkg::addr_t   npc,
    input  logic               valid,
    input  logic               spec,
    input  fetch_pkg::word_t   fetch_data,
    input  logic               fetch_ready,
    output fetch_pkg::addr_t   fetch_addr,
    output fetch_pkg::word_t   instr,
    output logic               stall
);

    fetch_pkg::word_t    mem [2**fetch_pkg::PREFETCH_DEPTH];

    fetch_pkg::buf_idx_t waddr;
    fetch_pkg::buf_idx_t raddr1;
    fetch_pkg::buf_idx_t raddr2;
    logic                oflow;
    logic                flush_pend;
    fetch_pkg::addr_t    fpc;

    logic                wren;
    logic                rden1;
    logic                rden2;
    logic                wden1;
    logic                wden2;
    logic                avail1;
    logic                avail2;
    logic                retire;
    logic                oflow_next;
    fetch_pkg::word_t    rdata1;
    fetch_pkg::word_t    rdata2;

    assign fetch_addr = fpc;

    always_comb begin
        // the buffer is full when the write pointer has lapped the read pointer.
        wren = fetch_ready & ~(oflow & (waddr == raddr1)) & ~spec & ~flush_pend;

        rden1 = oflow | (raddr1 != waddr);
        rden2 = rden1 & (raddr2 != waddr);

        // a word being written this cycle is forwarded to the read side.
        wden1 = wren & ~rden1 & (waddr == raddr1);
        wden2 = wren & ~rden2 & (waddr == raddr2);

        rdata1 = wden1 ? fetch_data : mem[raddr1];
        rdata2 = wden2 ? fetch_data : mem[raddr2];
        avail1 = rden1 | wden1;
        avail2 = rden2 | wden2;

        instr = fetch_pkg::NOP_INSTR;
        stall = 1'b0;
        if (!pc[1]) begin
            if (!avail1) begin
                stall = 1'b1;
            end else if (rdata1[1:0] == 2'b11) begin
                instr = rdata1;
            end else begin
                instr = {16'h0000, rdata1[15:0]};
            end
        end else begin
            if (!avail1) begin
                stall = 1'b1;
            end else if (rdata1[17:16] == 2'b11) begin
                // full-length instruction split across two entries.
                if (avail2) begin
                    instr = {rdata2[15:0], rdata1[31:16]};
                end else begin
                    stall = 1'b1;
                end
            end else begin
                instr = {16'h0000, rdata1[31:16]};
            end
        end

        // a word retires once the consumed instruction reaches its upper end.
        retire = valid & ~stall & (pc[1] | (instr[1:0] == 2'b11));

        oflow_next = oflow;
        if (wren && (waddr == '1)) begin
            oflow_next = 1'b1;
        end
        if (retire && (raddr1 == '1)) begin
            oflow_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            waddr      <= '0;
            raddr1     <= '0;
            raddr2     <= fetch_pkg::buf_idx_t'(1);
            oflow      <= 1'b0;
            flush_pend <= 1'b0;
            fpc        <= '0;
        end else if (spec) begin
            waddr      <= '0;
            raddr1     <= '0;
            raddr2     <= fetch_pkg::buf_idx_t'(1);
            oflow      <= 1'b0;
            flush_pend <= 1'b1;
        end else begin
            oflow <= oflow_next;
            if (wren) begin
                waddr <= waddr + 1'b1;
                fpc   <= fpc + 32'd4;
            end
            if (retire) begin
                raddr1 <= raddr1 + 1'b1;
                raddr2 <= raddr2 + 1'b1;
            end
            // the first strobe after a flush only restarts the fetch address.
            if (fetch_ready && flush_pend) begin
                fpc        <= {npc[31:2], 2'b00};
                flush_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[waddr] <= fetch_data;
        end
    end

endmodule

/* src/pc_sequencer.sv */
`timescale 1ns/1ps

module pc_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_target,
    input  fetch_pkg::word_t  instr,
    input  logic              stall,
    output fetch_pkg::addr_t  pc,
    output fetch_pkg::addr_t  npc,
    output logic              valid,
    output logic              spec,
    output logic              issue_take
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SPEC,
        SEQ_RUN
    } seq_state_t;

    seq_state_t       state;
    fetch_pkg::addr_t step;

    always_comb begin
        // nothing may be taken while a redirect is being sampled.
        valid      = (state == SEQ_RUN) & ~redirect;
        spec       = (state == SEQ_SPEC);
        issue_take = valid & ~stall;
        step       = (instr[1:0] == 2'b11) ? 32'd4 : 32'd2;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= SEQ_IDLE;
            pc    <= '0;
            npc   <= '0;
        end else if (redirect) begin
            state <= SEQ_SPEC;
            pc    <= redirect_target;
            npc   <= redirect_target;
        end else begin
            state <= SEQ_RUN;
            if (issue_take) begin
                pc <= pc + step;
            end
        end
    end

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_take,
    input  fetch_pkg::addr_t  pc,
    input  fetch_pkg::word_t  instr,
    output logic              issue_valid,
    output fetch_pkg::addr_t  issue_pc,
    output fetch_pkg::word_t  issue_instr,
    output logic              issue_compressed
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            issue_valid      <= 1'b0;
            issue_pc         <= '0;
            issue_instr      <= fetch_pkg::NOP_INSTR;
            issue_compressed <= 1'b0;
        end else begin
            issue_valid <= issue_take;
            if (issue_take) begin
                issue_pc    <= pc;
                issue_instr <= instr;
                // anything not ending in 11 is a 16-bit encoding.
                issue_compressed <= (instr[1:0] != 2'b11);
            end
        end
    end

endmodule

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              rst,
    output fetch_pkg::addr_t  fetch_addr,
    input  fetch_pkg::word_t  fetch_data,
    input  logic              fetch_ready,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_target,
    output logic              issue_valid,
    output fetch_pkg::addr_t  issue_pc,
    output fetch_pkg::word_t  issue_instr,
    output logic              issue_compressed
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t npc;
    fetch_pkg::word_t instr;
    logic             valid;
    logic             spec;
    logic             stall;
    logic             issue_take;

    pc_sequencer u_pc_sequencer (
        .clk             (clk),
        .rst             (rst),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .instr           (instr),
        .stall           (stall),
        .pc              (pc),
        .npc             (npc),
        .valid           (valid),
        .spec            (spec),
        .issue_take      (issue_take)
    );

    prefetch_buffer u_prefetch_buffer (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .npc         (npc),
        .valid       (valid),
        .spec        (spec),
        .fetch_data  (fetch_data),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .instr       (instr),
        .stall       (stall)
    );

    issue_stage u_issue_stage (
        .clk              (clk),
        .rst              (rst),
        .issue_take       (issue_take),
        .pc               (pc),
        .instr            (instr),
        .issue_valid      (issue_valid),
        .issue_pc         (issue_pc),
        .issue_instr      (issue_instr),
        .issue_compressed (issue_compressed)
    );

endmodule

/* verification/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    localparam int          CLK_PERIOD      = 100;
    localparam int          RESET_CYCLES    = 10;
    localparam int          CYCLES_PER_ITEM = 20;
    localparam int unsigned SEED            = 32'hb7d7;

    logic             clk;
    logic             rst;
    fetch_pkg::addr_t fetch_addr;
    fetch_pkg::word_t fetch_data;
    logic             fetch_ready;
    logic             redirect;
    fetch_pkg::addr_t redirect_target;
    logic             issue_valid;
    fetch_pkg::addr_t issue_pc;
    fetch_pkg::word_t issue_instr;
    logic             issue_compressed;

    // memory image, redirect events and expected stream from the cases file.
    fetch_pkg::addr_t img_addr [$];
    fetch_pkg::word_t img_word [$];
    int               redir_count [$];
    fetch_pkg::addr_t redir_target [$];
    fetch_pkg::addr_t exp_pc [$];
    fetch_pkg::word_t exp_instr [$];

    int watchdog_cycles = 0;
    int issued          = 0;
    int strobes         = 0;

    fetch_top dut (
        .clk              (clk),
        .rst              (rst),
        .fetch_addr       (fetch_addr),
        .fetch_data       (fetch_data),
        .fetch_ready      (fetch_ready),
        .redirect         (redirect),
        .redirect_target  (redirect_target),
        .issue_valid      (issue_valid),
        .issue_pc         (issue_pc),
        .issue_instr      (issue_instr),
        .issue_compressed (issue_compressed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("=== FAIL ===");
        $fatal(1, "%s", reason);
    endtask

    task automatic load_cases;
        integer                  fd;
        integer                  code;
        integer                  count;
        logic [63:0]             kind;
        logic [8*160-1:0]        rest;
        fetch_pkg::addr_t        addr;
        fetch_pkg::word_t        word;
        fd = $fopen("verification/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/fetch_cases.txt");
            fail_run("stimulus file missing");
        end else begin
            code = $fscanf(fd, " %s", kind);
            while (code == 1) begin
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else if (kind == "m") begin
                    code = $fscanf(fd, " %h %h", addr, word);
                    img_addr.push_back(addr);
                    img_word.push_back(word);
                end else if (kind == "r") begin
                    code = $fscanf(fd, " %d %h", count, addr);
                    redir_count.push_back(count);
                    redir_target.push_back(addr);
                end else if (kind == "x") begin
                    code = $fscanf(fd, " %h %h", addr, word);
                    exp_pc.push_back(addr);
                    exp_instr.push_back(word);
                end else begin
                    $display("unknown record kind in the cases file");
                    fail_run("bad cases file");
                end
                code = $fscanf(fd, " %s", kind);
            end
            $fclose(fd);
        end
    endtask

    // addresses outside the image read as zero.
    function automatic fetch_pkg::word_t memory_word(input fetch_pkg::addr_t addr);
        int i;
        memory_word = '0;
        for (i = 0; i < img_addr.size(); i++) begin
            if (img_addr[i] == addr) begin
                memory_word = img_word[i];
            end
        end
    endfunction

    task automatic check_issue;
        fetch_pkg::addr_t pc_exp;
        fetch_pkg::word_t instr_exp;
        logic             comp_exp;
        pc_exp    = exp_pc[issued];
        instr_exp = exp_instr[issued];
        comp_exp  = (instr_exp[1:0] != 2'b11);
        assert (issue_pc == pc_exp && issue_instr == instr_exp) else begin
            $display("Error at time %0t: item %0d expected pc %h instr %h, got pc %h instr %h",
                     $time, issued, pc_exp, instr_exp, issue_pc, issue_instr);
            fail_run("issued instruction differs from the expected stream");
        end
        assert (issue_compressed == comp_exp) else begin
            $display("Error at time %0t: pc %h instr %h expected compressed %b, got %b",
                     $time, issue_pc, issue_instr, comp_exp, issue_compressed);
            fail_run("compressed flag differs from the length rule");
        end
        issued++;
    endtask

    // outputs are sampled here, mid-cycle, before the next inputs are driven.
    task automatic drive_cycle;
        redirect = 1'b0;
        if (issue_valid) begin
            assert (strobes > 0) else begin
                $display("an instruction issued before any word was fetched");
                fail_run("issue before fetch");
            end
            check_issue();
            if (redir_count.size() > 0 && redir_count[0] == issued) begin
                redirect        = 1'b1;
                redirect_target = redir_target.pop_front();
                void'(redir_count.pop_front());
            end
        end
        fetch_ready = ($urandom % 2) == 1;
        fetch_data  = memory_word(fetch_addr);
        if (fetch_ready) begin
            strobes++;
        end
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        rst             = 1'b0;
        fetch_ready     = 1'b0;
        fetch_data      = '0;
        redirect        = 1'b0;
        redirect_target = '0;
        load_cases();
        watchdog_cycles = exp_pc.size() * CYCLES_PER_ITEM + RESET_CYCLES;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!issue_valid) else begin
                $display("issue_valid went high while reset was held");
                fail_run("issue during reset");
            end
        end
        rst = 1'b1;
        while (issued < exp_pc.size()) begin
            @(negedge clk);
            drive_cycle();
        end
        assert (redir_count.size() == 0) else begin
            $display("some redirect events were never reached by the issue stream");
            fail_run("unused redirect events");
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the issue stream did not complete within %0d cycles",
                 watchdog_cycles);
        fail_run("watchdog timeout");
    end

endmodule

/* verification/fetch_cases.txt */
# m: byte address and word of the memory image. r: issue count (decimal) and redirect target.
# x: expected issue pc and instruction, in issue order. Addresses and words are hex.
m 00000000 00100093
m 00000004 00200113
m 00000008 00308193
m 0000000c 00410213
m 00000010 80824505
m 00000014 02930001
m 00000018 83130050
m 0000001c 46810062
m 00000020 00730393
m 00000024 07850709
m 00000028 00840413
m 0000002c 00948493
m 00000030 00a50513
m 00000034 06110591
m 00000038 00b58593
m 0000003c 00c60613
m 00000040 01000793
m 00000044 01100813
m 00000048 08850805
m 0000004c 01200893
m 00000100 86931111
m 00000104 470100d6
m 00000108 00e70713
m 0000010c 8b850795
r 20 00000102
r 25 00000036
x 00000000 00100093
x 00000004 00200113
x 00000008 00308193
x 0000000c 00410213
x 00000010 00004505
x 00000012 00008082
x 00000014 00000001
x 00000016 00500293
x 0000001a 00628313
x 0000001e 00004681
x 00000020 00730393
x 00000024 00000709
x 00000026 00000785
x 00000028 00840413
x 0000002c 00948493
x 00000030 00a50513
x 00000034 00000591
x 00000036 00000611
x 00000038 00b58593
x 0000003c 00c60613
x 00000102 00d68693
x 00000106 00004701
x 00000108 00e70713
x 0000010c 00000795
x 0000010e 00008b85
x 00000036 00000611
x 00000038 00b58593
x 0000003c 00c60613
x 00000040 01000793
x 00000044 01100813
x 00000048 00000805
x 0000004a 00000885
x 0000004c 01200893

/* flist.f */
src/fetch_pkg.sv
src/prefetch_buffer.sv
src/pc_sequencer.sv
src/issue_stage.sv
src/fetch_top.sv
verification/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - src/fetch_pkg.sv
      - src/prefetch_buffer.sv
      - src/pc_sequencer.sv
      - src/issue_stage.sv
      - src/fetch_top.sv
  - target: test
    files:
      - verification/fetch_tb.sv
